// ==== ooo_defines.svh ====
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// reorder buffer entries
// also the size of the dispatch credit pool
`define OOO_ROB_DEPTH 8

// buffer tag width, log2 of the depth
// pointers wrap on overflow, so depth is a power of two
`define OOO_TAG_W 3

// data and pc width
`define OOO_XLEN 32

// architectural integer registers
`define OOO_NREGS 32

`endif

// ==== rob_pkg.sv ====
`include "ooo_defines.svh"

package rob_pkg;

    // retirement kind carried by every buffer entry
    typedef enum logic [1:0] {
        op_alu    = 2'd0,
        op_store  = 2'd1,
        op_branch = 2'd2,
        op_jalr   = 2'd3
    } op_e;

    // entry index into the buffer
    typedef logic [`OOO_TAG_W-1:0] tag_t;

    // credit count, 0 up to the full depth
    typedef logic [`OOO_TAG_W:0] count_t;

    // true for kinds that write rd at retirement
    // stores and branches leave the register file alone
    function automatic logic op_writes_rd(op_e op);
        return (op == op_alu) || (op == op_jalr);
    endfunction

endpackage

// ==== trace_pkg.sv ====
`include "ooo_defines.svh"

package trace_pkg;

    // width of the running retirement counter
    localparam int ORDER_W = 64;

    // width of a register index
    localparam int REG_ADDR_W = $clog2(`OOO_NREGS);

    // retirement order number, starts at 0 after reset
    typedef logic [ORDER_W-1:0] order_t;

    // architectural register index
    // x0 doubles as "no destination" in the trace
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

endpackage

// ==== reorder_buffer.sv ====
`include "ooo_defines.svh"

module reorder_buffer (
    input  logic                 itf,
    input  logic                 rst,
    // dispatch, one entry per cycle at the tail
    input  logic                 disp_valid,
    input  rob_pkg::op_e         disp_op,
    input  logic [`OOO_XLEN-1:0] disp_pc,
    input  logic [`OOO_XLEN-1:0] disp_pred_pc,
    input  trace_pkg::reg_addr_t disp_rd,
    // writeback by tag, any order
    input  logic                 wb_valid,
    input  rob_pkg::tag_t        wb_tag,
    input  logic [`OOO_XLEN-1:0] wb_data,
    input  logic [`OOO_XLEN-1:0] wb_next_pc,
    // retirement view of the head entry
    output logic                 ret_valid,
    output rob_pkg::op_e         ret_op,
    output logic [`OOO_XLEN-1:0] ret_pc,
    output logic [`OOO_XLEN-1:0] ret_next_pc,
    output trace_pkg::reg_addr_t ret_rd,
    output logic [`OOO_XLEN-1:0] ret_data,
    output logic                 ret_mispredict,
    // credits back to the dispatcher
    output logic                 credit_valid,
    output rob_pkg::count_t      credit_count,
    // fetch redirect after a mispredict
    output logic                 redirect_valid,
    output logic [`OOO_XLEN-1:0] redirect_pc
);

    // per-entry control bits
    logic                 valid_q [`OOO_ROB_DEPTH];
    logic                 done_q  [`OOO_ROB_DEPTH];

    // per-entry payload
    rob_pkg::op_e         op_q    [`OOO_ROB_DEPTH];
    logic [`OOO_XLEN-1:0] pc_q    [`OOO_ROB_DEPTH];
    logic [`OOO_XLEN-1:0] pred_q  [`OOO_ROB_DEPTH];
    trace_pkg::reg_addr_t rd_q    [`OOO_ROB_DEPTH];
    logic [`OOO_XLEN-1:0] data_q  [`OOO_ROB_DEPTH];
    logic [`OOO_XLEN-1:0] next_q  [`OOO_ROB_DEPTH];

    // oldest entry, next free slot, live entries
    rob_pkg::tag_t        head_q;
    rob_pkg::tag_t        tail_q;
    rob_pkg::count_t      count_q;

    // tail after this cycle's dispatch
    rob_pkg::tag_t        tail_nxt;

    assign tail_nxt = tail_q + rob_pkg::tag_t'(disp_valid);

    // head is retirable once its result is back
    assign ret_valid   = valid_q[head_q] & done_q[head_q];
    assign ret_op      = op_q[head_q];
    assign ret_pc      = pc_q[head_q];
    assign ret_next_pc = next_q[head_q];
    assign ret_rd      = rd_q[head_q];
    assign ret_data    = data_q[head_q];

    // actual next pc against the prediction made at fetch
    assign ret_mispredict = ret_valid & (next_q[head_q] != pred_q[head_q]);

    // control state, pointers and occupancy
    always_ff @(posedge itf) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < `OOO_ROB_DEPTH; i++) begin
                valid_q[i] <= 1'b0;
                done_q[i]  <= 1'b0;
            end
        end else begin
            // allocate at the tail, result still pending
            if (disp_valid) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
            end
            // result arrived for a live entry
            if (wb_valid) begin
                done_q[wb_tag] <= 1'b1;
            end
            // head leaves the buffer
            if (ret_valid) begin
                valid_q[head_q] <= 1'b0;
            end
            // mispredict kills everything younger
            // including a dispatch landing on this same edge
            if (ret_mispredict) begin
                for (int i = 0; i < `OOO_ROB_DEPTH; i++) begin
                    valid_q[i] <= 1'b0;
                end
            end

            // tail keeps counting so tags follow allocation order
            tail_q <= tail_nxt;
            if (ret_mispredict) begin
                head_q  <= tail_nxt;
                count_q <= '0;
            end else begin
                head_q  <= head_q + rob_pkg::tag_t'(ret_valid);
                count_q <= count_q + rob_pkg::count_t'(disp_valid)
                                   - rob_pkg::count_t'(ret_valid);
            end
        end
    end

    // entry payload written at dispatch and writeback
    always_ff @(posedge itf) begin
        if (disp_valid) begin
            op_q[tail_q]   <= disp_op;
            pc_q[tail_q]   <= disp_pc;
            pred_q[tail_q] <= disp_pred_pc;
            rd_q[tail_q]   <= disp_rd;
        end
        if (wb_valid) begin
            data_q[wb_tag] <= wb_data;
            next_q[wb_tag] <= wb_next_pc;
        end
    end

    // credit and redirect, one cycle after retirement
    always_ff @(posedge itf) begin
        if (rst) begin
            credit_valid   <= 1'b0;
            credit_count   <= '0;
            redirect_valid <= 1'b0;
        end else begin
            credit_valid   <= ret_valid;
            redirect_valid <= ret_mispredict;
            if (!ret_valid) begin
                credit_count <= '0;
            end else if (ret_mispredict) begin
                // every live entry comes back at once
                credit_count <= count_q + rob_pkg::count_t'(disp_valid);
            end else begin
                credit_count <= rob_pkg::count_t'(1);
            end
        end
    end

    // redirect target is the resolved next pc
    always_ff @(posedge itf) begin
        if (ret_mispredict) begin
            redirect_pc <= next_q[head_q];
        end
    end

endmodule

// ==== arch_regfile.sv ====
`include "ooo_defines.svh"

module arch_regfile (
    input  logic                 itf,
    input  logic                 rst,
    // retirement write port
    input  logic                 ret_valid,
    input  rob_pkg::op_e         ret_op,
    input  trace_pkg::reg_addr_t ret_rd,
    input  logic [`OOO_XLEN-1:0] ret_data,
    // read port
    input  trace_pkg::reg_addr_t rs_addr,
    output logic [`OOO_XLEN-1:0] rs_data
);

    logic [`OOO_XLEN-1:0] regs_q [`OOO_NREGS];

    // write only for kinds with a destination
    logic wr_en;

    assign wr_en = ret_valid && rob_pkg::op_writes_rd(ret_op) && (ret_rd != '0);

    always_ff @(posedge itf) begin
        if (rst) begin
            for (int i = 0; i < `OOO_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            // x0 is filtered in wr_en and stays zero
            regs_q[ret_rd] <= ret_data;
        end
    end

    // combinational read
    assign rs_data = regs_q[rs_addr];

endmodule

// ==== commit_tracer.sv ====
`include "ooo_defines.svh"

module commit_tracer (
    input  logic                 itf,
    input  logic                 rst,
    // retirement from the buffer head
    input  logic                 ret_valid,
    input  rob_pkg::op_e         ret_op,
    input  logic [`OOO_XLEN-1:0] ret_pc,
    input  logic [`OOO_XLEN-1:0] ret_next_pc,
    input  trace_pkg::reg_addr_t ret_rd,
    input  logic [`OOO_XLEN-1:0] ret_data,
    // registered commit record
    output logic                 trace_valid,
    output trace_pkg::order_t    trace_order,
    output rob_pkg::op_e         trace_op,
    output logic [`OOO_XLEN-1:0] trace_pc_rdata,
    output logic [`OOO_XLEN-1:0] trace_pc_wdata,
    output trace_pkg::reg_addr_t trace_rd_addr,
    output logic [`OOO_XLEN-1:0] trace_rd_wdata
);

    // order number of the next retirement
    trace_pkg::order_t    order_q;

    // destination as the trace reports it
    trace_pkg::reg_addr_t rd_addr;

    // no destination for store and branch
    assign rd_addr = rob_pkg::op_writes_rd(ret_op) ? ret_rd : '0;

    always_ff @(posedge itf) begin
        if (rst) begin
            trace_valid <= 1'b0;
            order_q     <= '0;
        end else begin
            trace_valid <= ret_valid;
            if (ret_valid) begin
                order_q <= order_q + 1'b1;
            end
        end
    end

    // record fields latched on each retirement
    always_ff @(posedge itf) begin
        if (ret_valid) begin
            trace_order    <= order_q;
            trace_op       <= ret_op;
            trace_pc_rdata <= ret_pc;
            // actual next pc, covers jalr targets and mispredicts
            trace_pc_wdata <= ret_next_pc;
            trace_rd_addr  <= rd_addr;
            // zero data whenever rd reads as x0
            trace_rd_wdata <= (rd_addr != '0) ? ret_data : '0;
        end
    end

endmodule

// ==== ooo_commit_top.sv ====
`include "ooo_defines.svh"

module ooo_commit_top (
    input  logic                 itf,
    input  logic                 rst,
    // dispatch
    input  logic                 disp_valid,
    input  rob_pkg::op_e         disp_op,
    input  logic [`OOO_XLEN-1:0] disp_pc,
    input  logic [`OOO_XLEN-1:0] disp_pred_pc,
    input  trace_pkg::reg_addr_t disp_rd,
    // writeback
    input  logic                 wb_valid,
    input  rob_pkg::tag_t        wb_tag,
    input  logic [`OOO_XLEN-1:0] wb_data,
    input  logic [`OOO_XLEN-1:0] wb_next_pc,
    // register read
    input  trace_pkg::reg_addr_t rs_addr,
    output logic [`OOO_XLEN-1:0] rs_data,
    // commit trace
    output logic                 trace_valid,
    output trace_pkg::order_t    trace_order,
    output rob_pkg::op_e         trace_op,
    output logic [`OOO_XLEN-1:0] trace_pc_rdata,
    output logic [`OOO_XLEN-1:0] trace_pc_wdata,
    output trace_pkg::reg_addr_t trace_rd_addr,
    output logic [`OOO_XLEN-1:0] trace_rd_wdata,
    // redirect and credits
    output logic                 redirect_valid,
    output logic [`OOO_XLEN-1:0] redirect_pc,
    output logic                 credit_valid,
    output rob_pkg::count_t      credit_count
);

    // retirement bus from the buffer head
    logic                 ret_valid;
    rob_pkg::op_e         ret_op;
    logic [`OOO_XLEN-1:0] ret_pc;
    logic [`OOO_XLEN-1:0] ret_next_pc;
    trace_pkg::reg_addr_t ret_rd;
    logic [`OOO_XLEN-1:0] ret_data;

    reorder_buffer rob (
        .itf(itf), .rst(rst),
        .disp_valid(disp_valid), .disp_op(disp_op), .disp_pc(disp_pc),
        .disp_pred_pc(disp_pred_pc), .disp_rd(disp_rd),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_data(wb_data), .wb_next_pc(wb_next_pc),
        .ret_valid(ret_valid), .ret_op(ret_op), .ret_pc(ret_pc), .ret_next_pc(ret_next_pc),
        .ret_rd(ret_rd), .ret_data(ret_data),
        // flush is handled inside the buffer
        .ret_mispredict(),
        .credit_valid(credit_valid), .credit_count(credit_count),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    arch_regfile regfile (
        .itf(itf), .rst(rst),
        .ret_valid(ret_valid), .ret_op(ret_op), .ret_rd(ret_rd), .ret_data(ret_data),
        .rs_addr(rs_addr), .rs_data(rs_data)
    );

    commit_tracer tracer (
        .itf(itf), .rst(rst),
        .ret_valid(ret_valid), .ret_op(ret_op), .ret_pc(ret_pc), .ret_next_pc(ret_next_pc),
        .ret_rd(ret_rd), .ret_data(ret_data),
        .trace_valid(trace_valid), .trace_order(trace_order), .trace_op(trace_op),
        .trace_pc_rdata(trace_pc_rdata), .trace_pc_wdata(trace_pc_wdata),
        .trace_rd_addr(trace_rd_addr), .trace_rd_wdata(trace_rd_wdata)
    );

endmodule

// ==== ooo_commit_asserts.sv ====
`include "ooo_defines.svh"

module ooo_commit_asserts (
    input logic                  itf,
    input logic                  rst,
    input logic                  disp,
    input rob_pkg::count_t       live,
    input logic                  credit_valid,
    input rob_pkg::count_t       credit_count,
    input logic                  ctrl,
    input logic                  rec_valid,
    input trace_pkg::order_t     rec_order
);
    timeunit 1ns;
    timeprecision 10ps;

    // credits spent at the boundary and not yet seen coming back
    int spent_q;

    always_ff @(posedge itf) begin
        if (rst) begin
            spent_q <= 0;
        end else begin
            spent_q <= spent_q + int'(disp) - (credit_valid ? int'(credit_count) : 0);
        end
    end

    // live entries plus credits in return flight match what was spent
    credit_conserved: assert property (@(posedge itf) disable iff (rst)
        (int'(live) + (credit_valid ? int'(credit_count) : 0)) == spent_q
        && spent_q <= `OOO_ROB_DEPTH)
        else $error("credit pool out of balance");

    // one record per order number
    record_once: assert property (@(posedge itf) disable iff (rst)
        rec_valid && $past(rec_valid) |-> rec_order != $past(rec_order))
        else $error("order number repeated");

    // registered controls come out of reset low
    quiet_after_reset: assert property (@(posedge itf) $fell(rst) |-> !ctrl)
        else $error("control output high right after reset");

endmodule

bind reorder_buffer ooo_commit_asserts rob_chk (
    .itf(itf), .rst(rst), .disp(disp_valid), .live(count_q),
    .credit_valid(credit_valid), .credit_count(credit_count),
    .ctrl(credit_valid | redirect_valid), .rec_valid(1'b0), .rec_order('0)
);

bind commit_tracer ooo_commit_asserts trace_chk (
    .itf(itf), .rst(rst), .disp(1'b0), .live('0),
    .credit_valid(1'b0), .credit_count('0),
    .ctrl(trace_valid), .rec_valid(trace_valid), .rec_order(trace_order)
);

// ==== ooo_commit_tb.sv ====
`include "ooo_defines.svh"

module ooo_commit_tb;
    timeunit 1ns;
    timeprecision 10ps;

    localparam int NREC = 300;
    localparam int LIMIT = 20000;

    logic itf, rst;
    logic disp_valid, wb_valid;
    rob_pkg::op_e disp_op;
    logic [31:0] disp_pc, disp_pred_pc, wb_data, wb_next_pc;
    trace_pkg::reg_addr_t disp_rd, rs_addr;
    rob_pkg::tag_t wb_tag;
    logic [31:0] rs_data, redirect_pc;
    logic trace_valid, redirect_valid, credit_valid;
    trace_pkg::order_t trace_order;
    rob_pkg::op_e trace_op;
    logic [31:0] trace_pc_rdata, trace_pc_wdata, trace_rd_wdata;
    trace_pkg::reg_addr_t trace_rd_addr;
    rob_pkg::count_t credit_count;

    ooo_commit_top uut (.*);

    logic [31:0] lfsr;
    int errs, fails, credits, disp_total, ret_total, seq, stalls, prog_n, exp_idx, cyc;
    logic wrong_path;
    logic [31:0] cur_pc, exp_redirect;
    // per-tag writeback still owed
    logic pend [8];
    logic [31:0] pend_data [8];
    logic [31:0] pend_next [8];
    // correct-path program in dispatch order
    rob_pkg::op_e prog_op [NREC];
    logic [31:0] prog_pc [NREC];
    logic [31:0] prog_next [NREC];
    logic [31:0] prog_data [NREC];
    logic [4:0] prog_rd [NREC];
    logic [31:0] ref_regs [32];

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errs++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // retire entry idx in the reference model
    // wrong-path work never enters the program, so the walk ends at each mispredict
    function automatic void ref_step(input int idx, output logic [4:0] rd,
                                     output logic [31:0] wd);
        logic writes;
        writes = (prog_op[idx] == rob_pkg::op_alu) || (prog_op[idx] == rob_pkg::op_jalr);
        rd = writes ? prog_rd[idx] : 5'd0;
        wd = (rd != 5'd0) ? prog_data[idx] : 32'd0;
        if (rd != 5'd0) begin
            ref_regs[rd] = prog_data[idx];
        end
    endfunction

    initial begin
        itf = 1'b0;
        forever #20 itf = ~itf;
    end

    // dispatcher and writeback unit
    always @(negedge itf) begin : drive
        int t;
        int s;
        logic [31:0] pc_n;
        logic [31:0] pred;
        logic [31:0] data;
        logic [4:0] rd;
        rob_pkg::op_e op;
        wb_valid = 1'b0;
        disp_valid = 1'b0;
        if (!rst) begin
            if (credit_valid) begin
                credits += int'(credit_count);
                ret_total += int'(credit_count);
            end
            if (redirect_valid) begin
                if (!wrong_path) begin
                    fails++;
                    $display("redirect seen with no mispredict in flight");
                end
                check("redirect_pc", redirect_pc, exp_redirect);
                // flushed entries get no writeback
                for (int i = 0; i < 8; i++) begin
                    pend[i] = 1'b0;
                end
                cur_pc = redirect_pc;
                wrong_path = 1'b0;
            end
            if (credits > `OOO_ROB_DEPTH) begin
                fails++;
                $display("more credits returned than were spent");
            end
            // complete one pending tag, random choice
            if (rand_bits(1) != 0) begin
                s = int'(rand_bits(3));
                for (int i = 0; i < 8; i++) begin
                    t = (s + i) % 8;
                    if (pend[t] && !wb_valid) begin
                        wb_valid = 1'b1;
                        wb_tag = rob_pkg::tag_t'(t);
                        wb_data = pend_data[t];
                        wb_next_pc = pend_next[t];
                        pend[t] = 1'b0;
                    end
                end
            end
            if (prog_n < NREC && credits == 0) begin
                stalls++;
            end
            if (prog_n < NREC && credits > 0 && rand_bits(2) != 0) begin
                op = rob_pkg::op_e'(2'(rand_bits(2)));
                pc_n = cur_pc + 32'd4;
                data = rand_bits(32);
                rd = 5'(rand_bits(5));
                if (op == rob_pkg::op_branch && rand_bits(1) != 0) begin
                    pc_n = cur_pc + 32'h40;
                end
                if (op == rob_pkg::op_jalr) begin
                    pc_n = rand_bits(10) << 2;
                    data = cur_pc + 32'd4;
                end
                pred = pc_n;
                // some control flow gets a wrong prediction
                if ((op == rob_pkg::op_branch || op == rob_pkg::op_jalr)
                    && rand_bits(2) == 0) begin
                    pred = pc_n + 32'd8;
                end
                disp_valid = 1'b1;
                disp_op = op;
                disp_pc = cur_pc;
                disp_pred_pc = pred;
                disp_rd = rd;
                // tag is allocation order modulo depth
                t = seq % 8;
                pend[t] = 1'b1;
                pend_data[t] = data;
                pend_next[t] = pc_n;
                seq++;
                credits--;
                disp_total++;
                if (!wrong_path) begin
                    prog_op[prog_n] = op;
                    prog_pc[prog_n] = cur_pc;
                    prog_next[prog_n] = pc_n;
                    prog_data[prog_n] = data;
                    prog_rd[prog_n] = rd;
                    prog_n++;
                    if (pred != pc_n) begin
                        wrong_path = 1'b1;
                        exp_redirect = pc_n;
                    end
                end
                // fetch follows the prediction
                cur_pc = pred;
            end
        end
    end

    // record compare
    always @(negedge itf) begin : compare
        logic [4:0] rd;
        logic [31:0] wd;
        if (!rst && trace_valid) begin
            if (exp_idx >= prog_n) begin
                fails++;
                $display("trace record with no matching instruction");
            end else begin
                ref_step(exp_idx, rd, wd);
                check("trace_order", trace_order, 64'(exp_idx));
                check("trace_op", trace_op, prog_op[exp_idx]);
                check("trace_pc_rdata", trace_pc_rdata, prog_pc[exp_idx]);
                check("trace_pc_wdata", trace_pc_wdata, prog_next[exp_idx]);
                check("trace_rd_addr", trace_rd_addr, rd);
                check("trace_rd_wdata", trace_rd_wdata, wd);
                exp_idx++;
            end
        end
    end

    initial begin
        lfsr = 32'h6663;
        errs = 0;
        fails = 0;
        credits = `OOO_ROB_DEPTH;
        disp_total = 0;
        ret_total = 0;
        seq = 0;
        stalls = 0;
        prog_n = 0;
        exp_idx = 0;
        wrong_path = 1'b0;
        cur_pc = 32'h1000;
        exp_redirect = '0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < 8; i++) begin
            pend[i] = 1'b0;
        end
        rst = 1'b1;
        disp_valid = 1'b0;
        disp_op = rob_pkg::op_alu;
        disp_pc = '0;
        disp_pred_pc = '0;
        disp_rd = '0;
        wb_valid = 1'b0;
        wb_tag = '0;
        wb_data = '0;
        wb_next_pc = '0;
        rs_addr = '0;
        repeat (16) @(negedge itf);
        rst = 1'b0;
        // run until the whole program has retired
        cyc = 0;
        while (exp_idx < NREC && cyc < LIMIT) begin
            @(negedge itf);
            cyc++;
        end
        if (exp_idx < NREC) begin
            fails++;
            $display("timeout waiting for the program to retire");
        end else begin
            // last credits come back in the cycle of the last record
            @(negedge itf);
            check("credit total", 64'(ret_total), 64'(disp_total));
            if (stalls == 0) begin
                fails++;
                $display("dispatch never ran out of credits");
            end
            for (int i = 0; i < 32; i++) begin
                rs_addr = trace_pkg::reg_addr_t'(i);
                @(negedge itf);
                check($sformatf("rs_data[%0d]", i), rs_data, ref_regs[i]);
            end
        end
        $display("errors: %0d value mismatches, %0d other failures", errs, fails);
        if (errs == 0 && fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
rob_pkg.sv
trace_pkg.sv
reorder_buffer.sv
arch_regfile.sv
commit_tracer.sv
ooo_commit_top.sv
ooo_commit_asserts.sv
ooo_commit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module ooo_commit_tb -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -qx "=== PASS ===" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
